// File: cache_pkg.sv
package cache_pkg;

  // address and data widths, in words
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W = WORDS_PER_LINE * WORD_W;
  localparam int OFFSET_W = $clog2(WORDS_PER_LINE);
  localparam int TAG_W = ADDR_W - OFFSET_W;

  // each cache is fully associative with this many lines
  localparam int NUM_LINES = 4;
  localparam int LINE_IDX_W = $clog2(NUM_LINES);

  // backing memory size, upper address bits are dropped
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  // cycles from mem_start to resp_valid
  localparam int MEM_LATENCY = 4;
  localparam int LAT_W = 3;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [LINE_W-1:0] line_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [LINE_IDX_W-1:0] line_idx_t;

  typedef enum logic [1:0] {
    arb_idle,
    arb_grant_1,
    arb_grant_2
  } arb_state_t;

  // reset content of a memory word: index in the low half, its inverse above
  function automatic word_t mem_init_word(input addr_t idx);
    word_t value;
    value = {~idx[WORD_W/2-1:0], idx[WORD_W/2-1:0]};
    return value;
  endfunction

endpackage

// File: line_store.sv
module line_store
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  tag_t  lookup_tag,
  output logic  hit,
  output line_t rd_line,
  input  logic  fill_en,
  input  tag_t  fill_tag,
  input  line_t fill_data,
  input  logic  inval_en
);

  logic [NUM_LINES-1:0] valid;
  logic [NUM_LINES-1:0] match;
  tag_t                 tags  [NUM_LINES];
  line_t                lines [NUM_LINES];
  line_idx_t            fill_ptr;

  // compare against every entry in parallel, matches are one-hot at most
  // so the read side can simply OR the selected lines together
  always_comb begin
    rd_line = '0;
    for (int i = 0; i < NUM_LINES; i++) begin
      match[i] = valid[i] && (tags[i] == lookup_tag);
      if (match[i]) begin
        rd_line = rd_line | lines[i];
      end
    end
  end

  assign hit = |match;

  // valid bits and the FIFO pointer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid    <= '0;
      fill_ptr <= '0;
    end else begin
      if (inval_en) begin
        valid <= valid & ~match;
      end else if (fill_en) begin
        valid[fill_ptr] <= 1'b1;
        // pointer wraps, so the oldest fill is the next victim
        fill_ptr <= fill_ptr + 1'b1;
      end
    end
  end

  // tag and data arrays
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tags[fill_ptr]  <= fill_tag;
      lines[fill_ptr] <= fill_data;
    end
  end

  // the controller only fills after a miss, so a tag can never sit twice
  a_single_match: assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(match)
  ) else $error("line_store: more than one valid entry matches the tag");

endmodule

// File: dcache.sv
module dcache
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  enable,
  input  logic  store,
  input  addr_t addr,
  input  word_t data_in,
  input  logic  grant,
  input  line_t fill_line,
  input  logic  resp_valid,
  output logic  mem_req,
  output logic  req_store,
  output addr_t req_addr,
  output word_t req_data,
  output logic  hit,
  output word_t data_out
);

  tag_t                lookup_tag;
  logic [OFFSET_W-1:0] word_sel;
  logic                line_hit;
  line_t               line_data;
  logic                resp_ours;
  logic                fill_en;
  logic                inval_en;

  // word address splits into a line tag and a word offset
  assign lookup_tag = addr[ADDR_W-1:OFFSET_W];
  assign word_sel   = addr[OFFSET_W-1:0];

  // the memory response is shared, only the granted cache may act on it
  assign resp_ours = grant & resp_valid;

  // a load miss allocates, a store drops any copy it finds
  assign fill_en  = enable & resp_ours & ~store & ~line_hit;
  assign inval_en = enable & resp_ours & store;

  line_store u_line_store (
    .clk        (clk),
    .arst_n     (arst_n),
    .lookup_tag (lookup_tag),
    .hit        (line_hit),
    .rd_line    (line_data),
    .fill_en    (fill_en),
    .fill_tag   (lookup_tag),
    .fill_data  (fill_line),
    .inval_en   (inval_en)
  );

  // stores always go to memory, loads only on a miss
  assign mem_req   = enable & (store | ~line_hit);
  assign req_store = store;
  assign req_addr  = addr;
  assign req_data  = data_in;

  // for a store, hit acts as the write acknowledge
  assign hit      = enable & (store ? resp_ours : line_hit);
  assign data_out = line_data[word_sel*WORD_W +: WORD_W];

  // the arbiter should never answer a cache that has no request up
  a_resp_needs_req: assert property (
    @(posedge clk) disable iff (!arst_n)
    resp_ours |-> mem_req
  ) else $error("dcache: granted response without an open request");

endmodule

// File: bus_arbiter.sv
module bus_arbiter
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  req_1,
  input  logic  req_2,
  input  logic  store_1,
  input  addr_t addr_1,
  input  word_t data_1,
  input  logic  store_2,
  input  addr_t addr_2,
  input  word_t data_2,
  output logic  grant_1,
  output logic  grant_2,
  output logic  mem_start,
  output logic  mem_store,
  output addr_t mem_addr,
  output word_t mem_data,
  input  logic  resp_valid
);

  arb_state_t state;
  arb_state_t state_next;
  logic       last_2;
  logic       last_2_next;
  logic       start_next;

  // on a tie, the port that was not served last wins
  always_comb begin
    state_next  = state;
    last_2_next = last_2;
    start_next  = 1'b0;
    case (state)
      arb_idle: begin
        if (req_1 && (!req_2 || last_2)) begin
          state_next  = arb_grant_1;
          last_2_next = 1'b0;
          start_next  = 1'b1;
        end else if (req_2) begin
          state_next  = arb_grant_2;
          last_2_next = 1'b1;
          start_next  = 1'b1;
        end
      end
      arb_grant_1, arb_grant_2: begin
        // the grant is held for the whole access
        if (resp_valid) begin
          state_next = arb_idle;
        end
      end
      default: state_next = arb_idle;
    endcase
  end

  // last_2 starts high so port 1 takes the first tie
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= arb_idle;
      last_2    <= 1'b1;
      mem_start <= 1'b0;
    end else begin
      state     <= state_next;
      last_2    <= last_2_next;
      mem_start <= start_next;
    end
  end

  assign grant_1 = (state == arb_grant_1);
  assign grant_2 = (state == arb_grant_2);

  assign mem_store = grant_2 ? store_2 : store_1;
  assign mem_addr  = grant_2 ? addr_2  : addr_1;
  assign mem_data  = grant_2 ? data_2  : data_1;

  a_grant_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(grant_1 && grant_2)
  ) else $error("bus_arbiter: both grants high");

  // memory must only answer an access this arbiter started
  a_no_resp_idle: assert property (
    @(posedge clk) disable iff (!arst_n)
    resp_valid |-> (state != arb_idle)
  ) else $error("bus_arbiter: resp_valid while idle");

endmodule

// File: mem_latency_timer.sv
module mem_latency_timer
  import cache_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  output logic done,
  output logic busy
);

  logic [LAT_W-1:0] count;

  // the start cycle and the memory output register take two of the
  // latency cycles, the counter covers the rest
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
      busy  <= 1'b0;
    end else if (start) begin
      count <= LAT_W'(MEM_LATENCY - 2);
      busy  <= 1'b1;
    end else if (busy) begin
      if (count == '0) begin
        busy <= 1'b0;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  assign done = busy && (count == '0);

  // the arbiter only starts a new access after the previous response
  a_no_overlap: assert property (
    @(posedge clk) disable iff (!arst_n)
    start |-> !busy
  ) else $error("mem_latency_timer: start while an access is in flight");

endmodule

// File: backing_memory.sv
module backing_memory
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  done,
  input  logic  store,
  input  addr_t addr,
  input  word_t wr_data,
  output line_t fill_line,
  output logic  resp_valid
);

  word_t                        mem [MEM_WORDS];
  logic [MEM_IDX_W-1:0]          word_idx;
  logic [MEM_IDX_W-OFFSET_W-1:0] line_base;

  // bits above the memory size are ignored
  assign word_idx  = addr[MEM_IDX_W-1:0];
  assign line_base = word_idx[MEM_IDX_W-1:OFFSET_W];

  // preload the known pattern so loads can be checked without prior stores
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = mem_init_word(addr_t'(i));
    end
  end

  // the fill line is read before the store lands, word 0 in the low bits
  always @(posedge clk) begin
    if (done) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
        fill_line[w*WORD_W +: WORD_W] <= mem[{line_base, OFFSET_W'(w)}];
      end
      if (store) begin
        mem[word_idx] <= wr_data;
      end
    end
  end

  // response follows the timer pulse by one cycle, alongside fill_line
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= done;
    end
  end

endmodule

// File: two_cache_top.sv
module two_cache_top
  import cache_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  enable_1,
  input  logic  store_1,
  input  addr_t addr_1,
  input  word_t data_in_1,
  output logic  hit_1,
  output word_t data_out_1,
  input  logic  enable_2,
  input  logic  store_2,
  input  addr_t addr_2,
  input  word_t data_in_2,
  output logic  hit_2,
  output word_t data_out_2
);

  // cache to arbiter
  logic  req_1;
  logic  req_store_1;
  addr_t req_addr_1;
  word_t req_data_1;
  logic  req_2;
  logic  req_store_2;
  addr_t req_addr_2;
  word_t req_data_2;
  logic  grant_1;
  logic  grant_2;

  // arbiter, timer and memory
  logic  mem_start;
  logic  mem_done;
  logic  mem_store;
  addr_t mem_addr;
  word_t mem_data;
  line_t fill_line;
  logic  resp_valid;

  dcache u_dcache_1 (
    .clk        (clk),
    .arst_n     (arst_n),
    .enable     (enable_1),
    .store      (store_1),
    .addr       (addr_1),
    .data_in    (data_in_1),
    .grant      (grant_1),
    .fill_line  (fill_line),
    .resp_valid (resp_valid),
    .mem_req    (req_1),
    .req_store  (req_store_1),
    .req_addr   (req_addr_1),
    .req_data   (req_data_1),
    .hit        (hit_1),
    .data_out   (data_out_1)
  );

  dcache u_dcache_2 (
    .clk        (clk),
    .arst_n     (arst_n),
    .enable     (enable_2),
    .store      (store_2),
    .addr       (addr_2),
    .data_in    (data_in_2),
    .grant      (grant_2),
    .fill_line  (fill_line),
    .resp_valid (resp_valid),
    .mem_req    (req_2),
    .req_store  (req_store_2),
    .req_addr   (req_addr_2),
    .req_data   (req_data_2),
    .hit        (hit_2),
    .data_out   (data_out_2)
  );

  bus_arbiter u_arbiter (
    .clk        (clk),
    .arst_n     (arst_n),
    .req_1      (req_1),
    .req_2      (req_2),
    .store_1    (req_store_1),
    .addr_1     (req_addr_1),
    .data_1     (req_data_1),
    .store_2    (req_store_2),
    .addr_2     (req_addr_2),
    .data_2     (req_data_2),
    .grant_1    (grant_1),
    .grant_2    (grant_2),
    .mem_start  (mem_start),
    .mem_store  (mem_store),
    .mem_addr   (mem_addr),
    .mem_data   (mem_data),
    .resp_valid (resp_valid)
  );

  mem_latency_timer u_timer (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (mem_start),
    .done   (mem_done),
    .busy   ()
  );

  backing_memory u_memory (
    .clk        (clk),
    .arst_n     (arst_n),
    .done       (mem_done),
    .store      (mem_store),
    .addr       (mem_addr),
    .wr_data    (mem_data),
    .fill_line  (fill_line),
    .resp_valid (resp_valid)
  );

endmodule

// File: tb_two_cache.sv
module tb_two_cache
  import cache_pkg::*;
;

  localparam int    TIMEOUT_CYCLES = 64;
  localparam int    MAX_ROWS       = 32;
  localparam int    DRIVE_DELAY    = 10;
  // the second pass moves every address to lines that the first pass never touched
  localparam addr_t PASS2_OFFSET   = 'h80;

  logic  clk;
  logic  arst_n;
  logic  enable_1;
  logic  store_1;
  addr_t addr_1;
  word_t data_in_1;
  logic  hit_1;
  word_t data_out_1;
  logic  enable_2;
  logic  store_2;
  addr_t addr_2;
  word_t data_in_2;
  logic  hit_2;
  word_t data_out_2;

  // stimulus table, one entry per access
  int    n_rows;
  int    row_port      [MAX_ROWS];
  bit    row_store     [MAX_ROWS];
  addr_t row_addr      [MAX_ROWS];
  word_t row_data      [MAX_ROWS];
  bit    row_first_hit [MAX_ROWS];

  // reference copy of the backing memory
  word_t model [MEM_WORDS];

  int rows_run;
  int rows_failed;
  int error_count;

  two_cache_top dut0 (
    .clk        (clk),
    .arst_n     (arst_n),
    .enable_1   (enable_1),
    .store_1    (store_1),
    .addr_1     (addr_1),
    .data_in_1  (data_in_1),
    .hit_1      (hit_1),
    .data_out_1 (data_out_1),
    .enable_2   (enable_2),
    .store_2    (store_2),
    .addr_2     (addr_2),
    .data_in_2  (data_in_2),
    .hit_2      (hit_2),
    .data_out_2 (data_out_2)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // each memory word starts as its index in the low half and the flipped index in the high half
  function automatic word_t init_pattern(input int idx);
    logic [WORD_W/2-1:0] low;
    low = idx[WORD_W/2-1:0];
    return {low ^ {(WORD_W/2){1'b1}}, low};
  endfunction

  task add_row(input int port, input bit st, input addr_t a, input bit first_hit);
    row_port[n_rows]      = port;
    row_store[n_rows]     = st;
    row_addr[n_rows]      = a;
    row_data[n_rows]      = st ? word_t'($urandom()) : '0;
    row_first_hit[n_rows] = first_hit;
    n_rows++;
  endtask

  // both ports run the same sequence on their own five lines
  task build_table;
    addr_t base;
    for (int p = 1; p <= 2; p++) begin
      base = (p == 1) ? addr_t'('h10) : addr_t'('h40);
      add_row(p, 1'b0, base + 'h01, 1'b0);
      add_row(p, 1'b0, base + 'h03, 1'b1);
      add_row(p, 1'b0, base + 'h00, 1'b1);
      // the store drops the cached line, so the reload must miss
      add_row(p, 1'b1, base + 'h02, 1'b0);
      add_row(p, 1'b0, base + 'h02, 1'b0);
      add_row(p, 1'b0, base + 'h05, 1'b0);
      add_row(p, 1'b0, base + 'h09, 1'b0);
      add_row(p, 1'b0, base + 'h0d, 1'b0);
      // fifth distinct line pushes out the oldest fill
      add_row(p, 1'b0, base + 'h12, 1'b0);
      add_row(p, 1'b0, base + 'h00, 1'b0);
      add_row(p, 1'b0, base + 'h11, 1'b1);
      add_row(p, 1'b0, base + 'h0e, 1'b1);
    end
  endtask

  task automatic drive_port(input int port, input logic en, input logic st,
                            input addr_t a, input word_t d);
    if (port == 1) begin
      enable_1  = en;
      store_1   = st;
      addr_1    = a;
      data_in_1 = d;
    end else begin
      enable_2  = en;
      store_2   = st;
      addr_2    = a;
      data_in_2 = d;
    end
  endtask

  function automatic logic port_hit(input int port);
    return (port == 1) ? hit_1 : hit_2;
  endfunction

  function automatic word_t port_data(input int port);
    return (port == 1) ? data_out_1 : data_out_2;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp,
                            inout int errs);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp,
                            inout int errs);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errs++;
    end
  endtask

  task automatic run_row(input int idx, input addr_t offset);
    int    port;
    addr_t a;
    logic  first_hit;
    int    cycles;
    int    errs;
    port   = row_port[idx];
    a      = row_addr[idx] + offset;
    cycles = 0;
    errs   = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    drive_port(port, 1'b1, row_store[idx], a, row_data[idx]);
    @(negedge clk);
    first_hit = port_hit(port);
    while (!port_hit(port) && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (!port_hit(port)) begin
      $display("timeout: port %0d saw no hit for address %h within %0d cycles",
               port, a, TIMEOUT_CYCLES);
      errs++;
    end else begin
      check_flag($sformatf("hit_%0d first cycle", port), first_hit, row_first_hit[idx], errs);
      if (row_store[idx]) begin
        model[a[MEM_IDX_W-1:0]] = row_data[idx];
      end else begin
        check_word($sformatf("data_out_%0d", port), port_data(port),
                   model[a[MEM_IDX_W-1:0]], errs);
      end
    end
    // hold the request through the edge that ends the response
    @(posedge clk);
    #DRIVE_DELAY;
    drive_port(port, 1'b0, 1'b0, '0, '0);
    rows_run++;
    error_count += errs;
    if (errs != 0) begin
      rows_failed++;
    end
    $display("row %0d port %0d %s at %h: %s", idx, port,
             row_store[idx] ? "store" : "load", a, (errs == 0) ? "ok" : "failed");
  endtask

  task automatic run_port(input int port, input addr_t offset);
    for (int i = 0; i < n_rows; i++) begin
      if (row_port[i] == port) begin
        run_row(i, offset);
      end
    end
  endtask

  initial begin
    void'($urandom(32'h339d));
    arst_n      = 1'b0;
    n_rows      = 0;
    rows_run    = 0;
    rows_failed = 0;
    error_count = 0;
    drive_port(1, 1'b0, 1'b0, '0, '0);
    drive_port(2, 1'b0, 1'b0, '0, '0);
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i] = init_pattern(i);
    end
    build_table();
    repeat (16) @(posedge clk);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    // first pass one access at a time, second pass both ports contend
    for (int i = 0; i < n_rows; i++) begin
      run_row(i, '0);
    end
    fork
      run_port(1, PASS2_OFFSET);
      run_port(2, PASS2_OFFSET);
    join

    @(posedge clk);
    $display("rows run %0d, rows failed %0d, errors %0d", rows_run, rows_failed, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
cache_pkg.sv
line_store.sv
dcache.sv
bus_arbiter.sv
mem_latency_timer.sv
backing_memory.sv
two_cache_top.sv
tb_two_cache.sv
